//--- hdl/zynq_map_pkg.sv
package zynq_map_pkg;

   // a host window address as it leaves the general purpose port
   localparam int unsigned host_addr_width = 32;

   // the core works on a full 64-bit physical address
   localparam int unsigned core_addr_width = 64;

   // board DRAM is addressed with 32 bits on the high performance port
   localparam int unsigned dram_addr_width = 32;

   // start of cached DRAM in the core address map
   // it is stripped by exclusive-or because every DRAM address has this bit set
   localparam logic [31:0] core_dram_base = 32'h8000_0000;

   // host address bit that splits the window into DRAM and local devices
   // a clear bit selects DRAM and a set bit selects the local device space
   localparam int unsigned window_select_bit = 29;

   // core address bit that marks the DRAM half of the inbound translation
   localparam int unsigned core_window_dram_bit = 31;

   // low address bits that pass through the window untouched, 256 MiB of reach
   localparam int unsigned window_offset_bits = 28;

   // DRAM that the host allocates for the core, 241 MiB
   // a re-based offset at or past this value lands outside the allocation
   localparam logic [31:0] dram_upper_limit = 32'd241 * 32'd1024 * 32'd1024;

   // the profiler splits the low 1 GiB of the core map into 8 MiB regions
   localparam int unsigned prof_regions = 128;

   // the region index is taken straight from these core address bits
   localparam int unsigned prof_region_lsb = 23;
   localparam int unsigned prof_region_msb = 29;
   localparam int unsigned prof_region_width = prof_region_msb - prof_region_lsb + 1;

endpackage

//--- hdl/host_reg_pkg.sv
package host_reg_pkg;

   // every host register and every queued MMIO word is one 32-bit word
   localparam int unsigned host_data_width = 32;

   // number of control registers the host can write
   localparam int unsigned host_reg_count = 4;
   localparam int unsigned host_reg_sel_width = 2;

   // write register map, in the order the host software expects
   typedef enum logic [host_reg_sel_width-1:0] {
      REG_BRIDGE_RESETN  = 2'd0,
      REG_DRAM_ALLOCATED = 2'd1,
      REG_DRAM_BASE      = 2'd2,
      REG_CORE_RESETN    = 2'd3
   } host_reg_e;

   // the read index has one extra top bit that selects the bitmap words
   localparam int unsigned host_read_idx_width = 3;

   // depth of the queue of captured MMIO writes and its counter widths
   localparam int unsigned mmio_fifo_depth = 4;
   localparam int unsigned mmio_ptr_width = 2;
   localparam int unsigned mmio_count_width = mmio_ptr_width + 1;

   // field positions inside one packed MMIO word, top bit first
   localparam int unsigned mmio_valid_bit = 31;
   localparam int unsigned mmio_addr_msb = 30;
   localparam int unsigned mmio_addr_lsb = 8;
   localparam int unsigned mmio_addr_width = mmio_addr_msb - mmio_addr_lsb + 1;
   localparam int unsigned mmio_data_msb = 7;
   localparam int unsigned mmio_data_lsb = 0;
   localparam int unsigned mmio_data_width = mmio_data_msb - mmio_data_lsb + 1;

endpackage

//--- hdl/host_reg_bank.sv
`timescale 1ns/1ps

module host_reg_bank
(
   input  logic                                          aclk_i,
   input  logic                                          arst_n_i,
   input  logic                                          csr_we_i,
   input  host_reg_pkg::host_reg_e                       csr_waddr_i,
   input  logic [host_reg_pkg::host_data_width-1:0]      csr_wdata_i,
   input  logic                                          csr_re_i,
   input  logic [host_reg_pkg::host_read_idx_width-1:0]  csr_raddr_i,
   input  logic [zynq_map_pkg::prof_regions-1:0]         prof_bitmap_i,
   output logic [host_reg_pkg::host_data_width-1:0]      csr_rdata_o,
   output logic                                          csr_rvalid_o,
   output logic                                          bridge_run_o,
   output logic                                          bridge_resetn_o,
   output logic                                          core_resetn_o,
   output logic [host_reg_pkg::host_data_width-1:0]      dram_base_o
);

   import host_reg_pkg::*;
   import zynq_map_pkg::*;

   // the four control registers, indexed by the write register enum
   logic [host_data_width-1:0] ctrl_r [host_reg_count];

   // the bitmap cut into 32-bit words with word 0 holding the lowest regions
   logic [prof_regions/host_data_width-1:0][host_data_width-1:0] prof_words;

   logic [host_data_width-1:0] rdata_sel;
   logic [host_data_width-1:0] rdata_r;
   logic                       rvalid_r;

   assign prof_words = prof_bitmap_i;

   // a host write lands on the clock edge that carries the strobe
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         for (int i = 0; i < host_reg_count; i++)
         begin
            ctrl_r[i] <= '0;
         end
      end
      else if (csr_we_i)
      begin
         ctrl_r[csr_waddr_i] <= csr_wdata_i;
      end
   end

   // the top index bit picks the bitmap half of the read map
   // the low bits then pick a register or a bitmap word
   always_comb
   begin
      if (csr_raddr_i[host_read_idx_width-1])
         rdata_sel = prof_words[csr_raddr_i[host_reg_sel_width-1:0]];
      else
         rdata_sel = ctrl_r[csr_raddr_i[host_reg_sel_width-1:0]];
   end

   // read data is captured with the strobe and shown one cycle later
   always_ff @(posedge aclk_i)
   begin
      if (csr_re_i)
         rdata_r <= rdata_sel;
   end

   // the valid pulse follows each read strobe by exactly one cycle
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         rvalid_r <= 1'b0;
      else
         rvalid_r <= csr_re_i;
   end

   assign csr_rdata_o  = rdata_r;
   assign csr_rvalid_o = rvalid_r;

   // bit 0 of the bridge register releases the profiler and the MMIO queue
   assign bridge_run_o    = ctrl_r[REG_BRIDGE_RESETN][0];
   assign bridge_resetn_o = ctrl_r[REG_BRIDGE_RESETN][0];

   // the core only leaves reset once the bridge around it is running as well
   assign core_resetn_o = ctrl_r[REG_CORE_RESETN][0] & ctrl_r[REG_BRIDGE_RESETN][0];

   // physical base of the DRAM block that the host allocated for the core
   assign dram_base_o = ctrl_r[REG_DRAM_BASE];

endmodule

//--- hdl/addr_translate.sv
`timescale 1ns/1ps

module addr_translate
(
   input  logic [zynq_map_pkg::host_addr_width-1:0] host_awaddr_i,
   input  logic [zynq_map_pkg::host_addr_width-1:0] host_araddr_i,
   input  logic                                     core_dram_awvalid_i,
   input  logic                                     core_dram_arvalid_i,
   input  logic [zynq_map_pkg::core_addr_width-1:0] core_dram_awaddr_i,
   input  logic [zynq_map_pkg::core_addr_width-1:0] core_dram_araddr_i,
   input  logic [zynq_map_pkg::dram_addr_width-1:0] dram_base_i,
   output logic [zynq_map_pkg::core_addr_width-1:0] core_awaddr_o,
   output logic [zynq_map_pkg::core_addr_width-1:0] core_araddr_o,
   output logic [zynq_map_pkg::dram_addr_width-1:0] dram_awaddr_o,
   output logic [zynq_map_pkg::dram_addr_width-1:0] dram_araddr_o,
   output logic                                     dram_range_err_o
);

   import zynq_map_pkg::*;

   // the interconnect has already removed the port base from host addresses
   // offset 0 is put back at core DRAM and offset 0x2000_0000 maps to core address 0
   function automatic logic [core_addr_width-1:0] inbound_xlate
      (input logic [host_addr_width-1:0] host_addr);
      logic [core_addr_width-1:0] core_addr;
      core_addr = '0;
      core_addr[window_offset_bits-1:0] = host_addr[window_offset_bits-1:0];
      core_addr[core_window_dram_bit] = ~host_addr[window_select_bit];
      return core_addr;
   endfunction

   // offset of a core DRAM access from the start of core DRAM
   function automatic logic [dram_addr_width-1:0] dram_offset
      (input logic [core_addr_width-1:0] core_addr);
      return core_addr[dram_addr_width-1:0] ^ core_dram_base;
   endfunction

   logic [dram_addr_width-1:0] aw_offset;
   logic [dram_addr_width-1:0] ar_offset;
   logic                       aw_high;
   logic                       ar_high;

   assign core_awaddr_o = inbound_xlate(host_awaddr_i);
   assign core_araddr_o = inbound_xlate(host_araddr_i);

   assign aw_offset = dram_offset(core_dram_awaddr_i);
   assign ar_offset = dram_offset(core_dram_araddr_i);

   // the offset is re-based onto the block the host allocated on the board
   assign dram_awaddr_o = aw_offset + dram_base_i;
   assign dram_araddr_o = ar_offset + dram_base_i;

   // only a presented access counts, idle address lines are ignored
   assign aw_high = core_dram_awvalid_i && (aw_offset >= dram_upper_limit);
   assign ar_high = core_dram_arvalid_i && (ar_offset >= dram_upper_limit);

   assign dram_range_err_o = aw_high | ar_high;

endmodule

//--- hdl/mem_profiler.sv
`timescale 1ns/1ps

module mem_profiler
(
   input  logic                                     aclk_i,
   input  logic                                     arst_n_i,
   input  logic                                     bridge_run_i,
   input  logic                                     core_dram_awvalid_i,
   input  logic                                     core_dram_arvalid_i,
   input  logic [zynq_map_pkg::core_addr_width-1:0] core_dram_awaddr_i,
   input  logic [zynq_map_pkg::core_addr_width-1:0] core_dram_araddr_i,
   output logic [zynq_map_pkg::prof_regions-1:0]    prof_bitmap_o
);

   import zynq_map_pkg::*;

   logic [prof_region_width-1:0] aw_region;
   logic [prof_region_width-1:0] ar_region;
   logic [prof_regions-1:0]      touch_mask;
   logic [prof_regions-1:0]      bitmap_r;

   // each 8 MiB region of the core map owns one bit of the bitmap
   assign aw_region = core_dram_awaddr_i[prof_region_msb:prof_region_lsb];
   assign ar_region = core_dram_araddr_i[prof_region_msb:prof_region_lsb];

   // a write and a read in the same cycle may mark two different regions
   always_comb
   begin
      touch_mask = '0;
      if (core_dram_awvalid_i)
         touch_mask[aw_region] = 1'b1;
      if (core_dram_arvalid_i)
         touch_mask[ar_region] = 1'b1;
   end

   // bits are sticky until the bridge is put back into reset by the host
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         bitmap_r <= '0;
      else if (!bridge_run_i)
         bitmap_r <= '0;
      else
         bitmap_r <= bitmap_r | touch_mask;
   end

   assign prof_bitmap_o = bitmap_r;

endmodule

//--- hdl/mmio_capture_fifo.sv
`timescale 1ns/1ps

module mmio_capture_fifo
(
   input  logic                                     aclk_i,
   input  logic                                     arst_n_i,
   input  logic                                     bridge_run_i,
   input  logic                                     io_v_i,
   input  logic                                     io_we_i,
   input  logic [zynq_map_pkg::core_addr_width-1:0] io_addr_i,
   input  logic [zynq_map_pkg::core_addr_width-1:0] io_data_i,
   input  logic                                     fifo_yumi_i,
   output logic                                     io_ready_o,
   output logic [host_reg_pkg::host_data_width-1:0] fifo_data_o,
   output logic                                     fifo_v_o
);

   import host_reg_pkg::*;

   logic [host_data_width-1:0]  mem_r [mmio_fifo_depth];
   logic [mmio_ptr_width-1:0]   wr_ptr_r;
   logic [mmio_ptr_width-1:0]   rd_ptr_r;
   logic [mmio_count_width-1:0] count_r;
   logic [host_data_width-1:0]  packed_word;
   logic                        full;
   logic                        push;
   logic                        pop;

   // only the low address and data bits survive into the host word
   // the top bit tells the host software that the word holds a write
   always_comb
   begin
      packed_word = '0;
      packed_word[mmio_valid_bit] = 1'b1;
      packed_word[mmio_addr_msb:mmio_addr_lsb] = io_addr_i[mmio_addr_width-1:0];
      packed_word[mmio_data_msb:mmio_data_lsb] = io_data_i[mmio_data_width-1:0];
   end

   assign full       = (count_r == mmio_count_width'(mmio_fifo_depth));
   assign io_ready_o = ~full;
   assign fifo_v_o   = (count_r != '0);

   // reads from the core are not captured, only writes enter the queue
   assign push = io_v_i & io_we_i & io_ready_o;
   assign pop  = fifo_yumi_i & fifo_v_o;

   // storage is only written on an accepted push
   always_ff @(posedge aclk_i)
   begin
      if (push)
         mem_r[wr_ptr_r] <= packed_word;
   end

   // pointers wrap on their own because the depth is a power of two
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else if (!bridge_run_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_r <= wr_ptr_r + 1'b1;
         if (pop)
            rd_ptr_r <= rd_ptr_r + 1'b1;
         // a push and a pop together leave the fill level where it is
         if (push && !pop)
            count_r <= count_r + 1'b1;
         else if (pop && !push)
            count_r <= count_r - 1'b1;
      end
   end

   // the oldest word is always on the output while the queue is not empty
   assign fifo_data_o = mem_r[rd_ptr_r];

endmodule

//--- hdl/zynq_bridge_top.sv
`timescale 1ns/1ps

module zynq_bridge_top
(
   input  logic                                          aclk_i,
   input  logic                                          arst_n_i,
   // host register port
   input  logic                                          csr_we_i,
   input  host_reg_pkg::host_reg_e                       csr_waddr_i,
   input  logic [host_reg_pkg::host_data_width-1:0]      csr_wdata_i,
   input  logic                                          csr_re_i,
   input  logic [host_reg_pkg::host_read_idx_width-1:0]  csr_raddr_i,
   output logic [host_reg_pkg::host_data_width-1:0]      csr_rdata_o,
   output logic                                          csr_rvalid_o,
   output logic                                          bridge_resetn_o,
   output logic                                          core_resetn_o,
   // host window into the core
   input  logic [zynq_map_pkg::host_addr_width-1:0]      host_awaddr_i,
   input  logic [zynq_map_pkg::host_addr_width-1:0]      host_araddr_i,
   output logic [zynq_map_pkg::core_addr_width-1:0]      core_awaddr_o,
   output logic [zynq_map_pkg::core_addr_width-1:0]      core_araddr_o,
   // core accesses to board DRAM
   input  logic                                          core_dram_awvalid_i,
   input  logic                                          core_dram_arvalid_i,
   input  logic [zynq_map_pkg::core_addr_width-1:0]      core_dram_awaddr_i,
   input  logic [zynq_map_pkg::core_addr_width-1:0]      core_dram_araddr_i,
   output logic [zynq_map_pkg::dram_addr_width-1:0]      dram_awaddr_o,
   output logic [zynq_map_pkg::dram_addr_width-1:0]      dram_araddr_o,
   output logic                                          dram_range_err_o,
   // core MMIO writes toward the host
   input  logic                                          io_v_i,
   input  logic                                          io_we_i,
   input  logic [zynq_map_pkg::core_addr_width-1:0]      io_addr_i,
   input  logic [zynq_map_pkg::core_addr_width-1:0]      io_data_i,
   output logic                                          io_ready_o,
   output logic [host_reg_pkg::host_data_width-1:0]      fifo_data_o,
   output logic                                          fifo_v_o,
   input  logic                                          fifo_yumi_i
);

   import host_reg_pkg::*;
   import zynq_map_pkg::*;

   // level from the bridge reset register that keeps the capture logic running
   logic                       bridge_run;
   // sticky region bitmap that the host reads back as four words
   logic [prof_regions-1:0]    prof_bitmap;
   // allocated DRAM base used to re-base every outbound address
   logic [host_data_width-1:0] dram_base;

   host_reg_bank u_reg_bank
   (
      .aclk_i          (aclk_i),
      .arst_n_i        (arst_n_i),
      .csr_we_i        (csr_we_i),
      .csr_waddr_i     (csr_waddr_i),
      .csr_wdata_i     (csr_wdata_i),
      .csr_re_i        (csr_re_i),
      .csr_raddr_i     (csr_raddr_i),
      .prof_bitmap_i   (prof_bitmap),
      .csr_rdata_o     (csr_rdata_o),
      .csr_rvalid_o    (csr_rvalid_o),
      .bridge_run_o    (bridge_run),
      .bridge_resetn_o (bridge_resetn_o),
      .core_resetn_o   (core_resetn_o),
      .dram_base_o     (dram_base)
   );

   // both translation directions are pure combinational logic
   addr_translate u_xlate
   (
      .host_awaddr_i       (host_awaddr_i),
      .host_araddr_i       (host_araddr_i),
      .core_dram_awvalid_i (core_dram_awvalid_i),
      .core_dram_arvalid_i (core_dram_arvalid_i),
      .core_dram_awaddr_i  (core_dram_awaddr_i),
      .core_dram_araddr_i  (core_dram_araddr_i),
      .dram_base_i         (dram_base),
      .core_awaddr_o       (core_awaddr_o),
      .core_araddr_o       (core_araddr_o),
      .dram_awaddr_o       (dram_awaddr_o),
      .dram_araddr_o       (dram_araddr_o),
      .dram_range_err_o    (dram_range_err_o)
   );

   // the profiler watches the core side addresses before re-basing
   mem_profiler u_profiler
   (
      .aclk_i              (aclk_i),
      .arst_n_i            (arst_n_i),
      .bridge_run_i        (bridge_run),
      .core_dram_awvalid_i (core_dram_awvalid_i),
      .core_dram_arvalid_i (core_dram_arvalid_i),
      .core_dram_awaddr_i  (core_dram_awaddr_i),
      .core_dram_araddr_i  (core_dram_araddr_i),
      .prof_bitmap_o       (prof_bitmap)
   );

   mmio_capture_fifo u_mmio
   (
      .aclk_i       (aclk_i),
      .arst_n_i     (arst_n_i),
      .bridge_run_i (bridge_run),
      .io_v_i       (io_v_i),
      .io_we_i      (io_we_i),
      .io_addr_i    (io_addr_i),
      .io_data_i    (io_data_i),
      .fifo_yumi_i  (fifo_yumi_i),
      .io_ready_o   (io_ready_o),
      .fifo_data_o  (fifo_data_o),
      .fifo_v_o     (fifo_v_o)
   );

endmodule

//--- tb/tb_zynq_bridge_cases.svh
`ifndef TB_ZYNQ_BRIDGE_CASES_SVH
`define TB_ZYNQ_BRIDGE_CASES_SVH

// inbound rows hold a host window address and the core address it must reach
// host bit 29 clear selects DRAM, which puts core bit 31 high
localparam int inb_rows = 8;

localparam logic [31:0] inb_host_addr [inb_rows] = '{
   32'h0000_0000,
   32'h0000_1234,
   32'h0FFF_FFFC,
   32'h2000_0000,
   32'h2000_0100,
   32'h3ABC_DEF0,
   32'hD123_4567,
   32'hF000_0008
};

// host bits 31 to 28 are dropped in the last three rows
localparam logic [63:0] inb_core_addr [inb_rows] = '{
   64'h0000_0000_8000_0000,
   64'h0000_0000_8000_1234,
   64'h0000_0000_8FFF_FFFC,
   64'h0000_0000_0000_0000,
   64'h0000_0000_0000_0100,
   64'h0000_0000_0ABC_DEF0,
   64'h0000_0000_8123_4567,
   64'h0000_0000_0000_0008
};

// outbound rows hold a core DRAM address, its offset from core DRAM start
// and whether that offset reaches the 241 MiB limit at 0x0F10_0000
localparam int out_rows = 8;

localparam logic [63:0] out_core_addr [out_rows] = '{
   64'h0000_0000_8000_0000,
   64'h0000_0000_8000_1000,
   64'h0000_0000_8F0F_FFFF,
   64'h0000_0000_8F10_0000,
   64'h0000_0000_8FFF_FFF0,
   64'h0000_0000_0000_0040,
   64'hFFFF_FFFF_8000_0800,
   64'h0000_0000_8A00_0000
};

// an address below core DRAM flips bit 31 on and lands far past the limit
localparam logic [31:0] out_offset [out_rows] = '{
   32'h0000_0000,
   32'h0000_1000,
   32'h0F0F_FFFF,
   32'h0F10_0000,
   32'h0FFF_FFF0,
   32'h8000_0040,
   32'h0000_0800,
   32'h0A00_0000
};

localparam logic out_high [out_rows] = '{
   1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0
};

// MMIO rows hold the core address and the 23-bit field the packed word keeps
localparam int mmio_rows = 5;

localparam logic [63:0] mmio_addr [mmio_rows] = '{
   64'h0000_0000_0000_0010,
   64'h0000_0000_0040_1000,
   64'h0000_0000_00FF_FFFC,
   64'hDEAD_BEEF_1234_5678,
   64'h0000_0000_7FFF_FFFF
};

localparam logic [22:0] mmio_addr_field [mmio_rows] = '{
   23'h00_0010,
   23'h40_1000,
   23'h7F_FFFC,
   23'h34_5678,
   23'h7F_FFFF
};

`endif

//--- tb/tb_zynq_bridge.sv
`timescale 1ns/1ps

module tb_zynq_bridge;

   import host_reg_pkg::*;
   import zynq_map_pkg::*;

   `include "tb_zynq_bridge_cases.svh"

   // longest any wait loop may spin before it gives up and counts a timeout
   localparam int unsigned wait_limit = 40;

   // signals carry the names of the DUT ports they connect to
   logic        aclk_i;
   logic        arst_n_i;
   logic        csr_we_i;
   host_reg_e   csr_waddr_i;
   logic [31:0] csr_wdata_i;
   logic        csr_re_i;
   logic [2:0]  csr_raddr_i;
   logic [31:0] csr_rdata_o;
   logic        csr_rvalid_o;
   logic        bridge_resetn_o;
   logic        core_resetn_o;
   logic [31:0] host_awaddr_i;
   logic [31:0] host_araddr_i;
   logic [63:0] core_awaddr_o;
   logic [63:0] core_araddr_o;
   logic        core_dram_awvalid_i;
   logic        core_dram_arvalid_i;
   logic [63:0] core_dram_awaddr_i;
   logic [63:0] core_dram_araddr_i;
   logic [31:0] dram_awaddr_o;
   logic [31:0] dram_araddr_o;
   logic        dram_range_err_o;
   logic        io_v_i;
   logic        io_we_i;
   logic [63:0] io_addr_i;
   logic [63:0] io_data_i;
   logic        io_ready_o;
   logic [31:0] fifo_data_o;
   logic        fifo_v_o;
   logic        fifo_yumi_i;

   int unsigned  errors;
   int unsigned  timeouts;
   logic [31:0]  dram_base;
   logic [31:0]  alloc_val;
   // bitmap the profiler should hold, one bit per 8 MiB region touched
   logic [127:0] exp_bitmap;
   logic [63:0]  mmio_data [mmio_rows];
   logic [31:0]  mmio_exp [mmio_rows];

   zynq_bridge_top u_dut (.*);

   always #4 aclk_i = ~aclk_i;

   task automatic report_error(input string msg);
      errors++;
      $display("Error at %0t ns: %s", $time, msg);
   endtask

   task automatic finish_run();
      $display("summary: %0d value errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   endtask

   // a write lands on the rising edge between the two falling edges
   task automatic write_reg(input host_reg_e idx, input logic [31:0] data);
      @(negedge aclk_i);
      csr_we_i    = 1'b1;
      csr_waddr_i = idx;
      csr_wdata_i = data;
      @(negedge aclk_i);
      csr_we_i = 1'b0;
   endtask

   // read data arrives exactly one cycle after the strobe
   // the valid pulse must be low again before the next strobe
   task automatic read_expect(input logic [2:0] idx, input logic [31:0] exp);
      @(negedge aclk_i);
      if (csr_rvalid_o !== 1'b0)
         report_error($sformatf("csr_rvalid_o high before read index %0d", idx));
      csr_re_i    = 1'b1;
      csr_raddr_i = idx;
      @(negedge aclk_i);
      csr_re_i = 1'b0;
      if (csr_rvalid_o !== 1'b1)
         report_error($sformatf("no csr_rvalid_o for read index %0d", idx));
      if (csr_rdata_o !== exp)
         report_error($sformatf("read index %0d gave %h, expected %h", idx, csr_rdata_o, exp));
   endtask

   // indices 4 to 7 return the bitmap, lowest regions first
   task automatic check_bitmap();
      for (int k = 0; k < 4; k++)
      begin
         read_expect(3'(4 + k), exp_bitmap[32*k +: 32]);
      end
   endtask

   task automatic wait_fifo_level(input logic level);
      int unsigned n;
      n = 0;
      while (fifo_v_o !== level && n < wait_limit)
      begin
         @(negedge aclk_i);
         n++;
      end
      if (fifo_v_o !== level)
      begin
         timeouts++;
         $display("timeout: fifo_v_o did not reach %0b within %0d cycles", level, wait_limit);
      end
   endtask

   task automatic wait_io_ready();
      int unsigned n;
      n = 0;
      while (!io_ready_o && n < wait_limit)
      begin
         @(negedge aclk_i);
         n++;
      end
      if (!io_ready_o)
      begin
         timeouts++;
         $display("timeout: io_ready_o stayed low for %0d cycles", wait_limit);
      end
   endtask

   // an address inside the given region with random bits around the index
   function automatic logic [63:0] region_addr(input int unsigned region);
      logic [63:0] addr;
      addr = {$urandom, $urandom} & 64'hFFFF_FFFF_C07F_FFFF;
      return addr | (64'(region) << 23);
   endfunction

   // one write and one read are presented together for a single cycle
   task automatic touch_regions(input int unsigned aw_reg, input int unsigned ar_reg);
      @(negedge aclk_i);
      core_dram_awvalid_i = 1'b1;
      core_dram_arvalid_i = 1'b1;
      core_dram_awaddr_i  = region_addr(aw_reg);
      core_dram_araddr_i  = region_addr(ar_reg);
      exp_bitmap[aw_reg]  = 1'b1;
      exp_bitmap[ar_reg]  = 1'b1;
      @(negedge aclk_i);
      core_dram_awvalid_i = 1'b0;
      core_dram_arvalid_i = 1'b0;
   endtask

   task automatic offer_mmio(input int row);
      @(negedge aclk_i);
      io_v_i    = 1'b1;
      io_we_i   = 1'b1;
      io_addr_i = mmio_addr[row];
      io_data_i = mmio_data[row];
   endtask

   // the write is taken on the edge after io_ready_o is seen high
   task automatic hand_over_mmio();
      wait_io_ready();
      @(negedge aclk_i);
      io_v_i = 1'b0;
   endtask

   task automatic pop_mmio(input logic [31:0] exp);
      wait_fifo_level(1'b1);
      if (fifo_data_o !== exp)
         report_error($sformatf("queue word %h, expected %h", fifo_data_o, exp));
      fifo_yumi_i = 1'b1;
      @(negedge aclk_i);
      fifo_yumi_i = 1'b0;
   endtask

   initial
   begin
      void'($urandom(32'h8b2a9582));
      errors = 0;
      timeouts = 0;
      aclk_i = 1'b0;
      arst_n_i = 1'b0;
      csr_we_i = 1'b0;
      csr_waddr_i = REG_BRIDGE_RESETN;
      csr_wdata_i = '0;
      csr_re_i = 1'b0;
      csr_raddr_i = '0;
      host_awaddr_i = '0;
      host_araddr_i = '0;
      core_dram_awvalid_i = 1'b0;
      core_dram_arvalid_i = 1'b0;
      core_dram_awaddr_i = '0;
      core_dram_araddr_i = '0;
      io_v_i = 1'b0;
      io_we_i = 1'b0;
      io_addr_i = '0;
      io_data_i = '0;
      fifo_yumi_i = 1'b0;
      exp_bitmap = '0;
      // each packed word is the valid mark, 23 address bits and one data byte
      for (int i = 0; i < mmio_rows; i++)
      begin
         mmio_data[i] = {$urandom, $urandom};
         mmio_exp[i]  = {1'b1, mmio_addr_field[i], mmio_data[i][7:0]};
      end
      repeat (2) @(negedge aclk_i);
      arst_n_i = 1'b1;

      if (bridge_resetn_o !== 1'b0 || core_resetn_o !== 1'b0)
         report_error("reset outputs not low after reset");
      if (fifo_v_o !== 1'b0 || io_ready_o !== 1'b1 || csr_rvalid_o !== 1'b0)
         report_error("queue or read handshake not idle after reset");
      for (int i = 0; i < 8; i++)
      begin
         read_expect(3'(i), 32'h0);
      end

      // core reset must stay asserted until the bridge bit is set too
      alloc_val = $urandom;
      write_reg(REG_DRAM_ALLOCATED, alloc_val);
      read_expect(3'd1, alloc_val);
      write_reg(REG_CORE_RESETN, 32'h1);
      read_expect(3'd3, 32'h1);
      if (core_resetn_o !== 1'b0)
         report_error("core_resetn_o high while the bridge bit is clear");
      write_reg(REG_BRIDGE_RESETN, 32'h1);
      read_expect(3'd0, 32'h1);
      if (bridge_resetn_o !== 1'b1 || core_resetn_o !== 1'b1)
         report_error("reset outputs not released with both bits set");
      write_reg(REG_CORE_RESETN, 32'h0);
      if (core_resetn_o !== 1'b0)
         report_error("core_resetn_o high with its own bit clear");
      write_reg(REG_CORE_RESETN, 32'h1);
      dram_base = $urandom & 32'hFFF0_0000;
      write_reg(REG_DRAM_BASE, dram_base);
      read_expect(3'd2, dram_base);

      // the read port takes the table in reverse so both ports see every row
      for (int i = 0; i < inb_rows; i++)
      begin
         @(negedge aclk_i);
         host_awaddr_i = inb_host_addr[i];
         host_araddr_i = inb_host_addr[inb_rows-1-i];
         #1;
         if (core_awaddr_o !== inb_core_addr[i])
            report_error($sformatf("core_awaddr_o %h for host %h", core_awaddr_o, host_awaddr_i));
         if (core_araddr_o !== inb_core_addr[inb_rows-1-i])
            report_error($sformatf("core_araddr_o %h for host %h", core_araddr_o, host_araddr_i));
      end

      // the range flag is checked once per port with only that port valid
      for (int i = 0; i < out_rows; i++)
      begin
         @(negedge aclk_i);
         core_dram_awvalid_i = 1'b1;
         core_dram_arvalid_i = 1'b0;
         core_dram_awaddr_i  = out_core_addr[i];
         core_dram_araddr_i  = out_core_addr[out_rows-1-i];
         #1;
         if (dram_awaddr_o !== out_offset[i] + dram_base)
            report_error($sformatf("dram_awaddr_o %h in row %0d", dram_awaddr_o, i));
         if (dram_araddr_o !== out_offset[out_rows-1-i] + dram_base)
            report_error($sformatf("dram_araddr_o %h in row %0d", dram_araddr_o, out_rows-1-i));
         if (dram_range_err_o !== out_high[i])
            report_error($sformatf("range flag %b on write row %0d", dram_range_err_o, i));
         core_dram_awvalid_i = 1'b0;
         core_dram_arvalid_i = 1'b1;
         #1;
         if (dram_range_err_o !== out_high[out_rows-1-i])
            report_error($sformatf("range flag %b on read row %0d", dram_range_err_o, out_rows-1-i));
      end
      // both ports hold offsets past the limit while neither is valid
      core_dram_arvalid_i = 1'b0;
      core_dram_awaddr_i  = out_core_addr[3];
      core_dram_araddr_i  = out_core_addr[4];
      #1;
      if (dram_range_err_o !== 1'b0)
         report_error("range flag high with no valid access");

      // pulse the bridge bit so the profiler starts from an empty bitmap
      write_reg(REG_BRIDGE_RESETN, 32'h0);
      write_reg(REG_BRIDGE_RESETN, 32'h1);
      check_bitmap();
      touch_regions(0, 127);
      touch_regions(5, 31);
      touch_regions(32, 64);
      // idle address lines must not mark anything
      @(negedge aclk_i);
      core_dram_awaddr_i = region_addr(77);
      core_dram_araddr_i = region_addr(78);
      check_bitmap();
      touch_regions(100, 5);
      touch_regions(63, 96);
      check_bitmap();

      // a core read on the MMIO port is not captured
      @(negedge aclk_i);
      io_v_i = 1'b1;
      @(negedge aclk_i);
      io_v_i = 1'b0;
      if (fifo_v_o !== 1'b0)
         report_error("MMIO read entered the queue");

      for (int i = 0; i < 4; i++)
      begin
         offer_mmio(i);
         hand_over_mmio();
      end
      if (io_ready_o !== 1'b0)
         report_error("io_ready_o still high with four words queued");
      // the fifth write is held against a full queue for two cycles
      offer_mmio(4);
      repeat (2) @(negedge aclk_i);
      if (io_ready_o !== 1'b0)
         report_error("io_ready_o rose before any pop");
      for (int i = 0; i < mmio_rows; i++)
      begin
         pop_mmio(mmio_exp[i]);
         if (i == 0)
            hand_over_mmio();
      end
      if (fifo_v_o !== 1'b0)
         report_error("fifo_v_o still high after the last pop");

      // clearing the bridge bit drops queued words and the bitmap
      offer_mmio(1);
      hand_over_mmio();
      offer_mmio(2);
      hand_over_mmio();
      wait_fifo_level(1'b1);
      write_reg(REG_BRIDGE_RESETN, 32'h0);
      wait_fifo_level(1'b0);
      if (bridge_resetn_o !== 1'b0 || core_resetn_o !== 1'b0)
         report_error("reset outputs not low after clearing the bridge bit");
      exp_bitmap = '0;
      check_bitmap();
      finish_run();
   end

endmodule

//--- project.f
+incdir+tb
hdl/zynq_map_pkg.sv
hdl/host_reg_pkg.sv
hdl/host_reg_bank.sv
hdl/addr_translate.sv
hdl/mem_profiler.sv
hdl/mmio_capture_fifo.sv
hdl/zynq_bridge_top.sv
tb/tb_zynq_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f project.f --top-module tb_zynq_bridge \
   --Mdir obj_dir -o tb_zynq_bridge \
   && ./obj_dir/tb_zynq_bridge > "$log" 2>&1 \
   || { echo "build or simulation did not complete"; cat "$log" 2>/dev/null; exit 1; }

cat "$log"

grep -q "ALL CHECKS PASSED" "$log" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
